//--- Makefile
# Verilator regression for the DisplayPort receive lane

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module tb_dp_rx_lane -Mdir obj_dir -f sources.f
	./obj_dir/Vtb_dp_rx_lane | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dp_regs_pkg.sv
// Register bus definitions for the receive lane
// Wishbone request and response bundles, the register map
// and the control and statistics structs

package dp_regs_pkg;

    typedef logic [3:0]  wb_adr_t;
    typedef logic [31:0] wb_dat_t;

    // Master to slave
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        wb_adr_t    adr;
        wb_dat_t    dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic       ack;
        wb_dat_t    dat;
    } wb_rsp_t;

    // En in bit 0, mst in bit 1 of reg_ctl
    typedef struct packed {
        logic       mst;
        logic       en;
    } dp_ctl_t;

    typedef logic [15:0] dp_stat_cnt_t;

    typedef struct packed {
        dp_stat_cnt_t   sr_cnt;
        dp_stat_cnt_t   lock_loss_cnt;
        dp_stat_cnt_t   k_cnt;
    } dp_stats_t;

    // Write-one bit in reg_ctl that clears the counters
    localparam int dp_stat_clr = 2;

    // Word addresses
    localparam wb_adr_t reg_ctl      = 4'd0;
    localparam wb_adr_t reg_status   = 4'd1;
    localparam wb_adr_t reg_sr_cnt   = 4'd2;
    localparam wb_adr_t reg_loss_cnt = 4'd3;
    localparam wb_adr_t reg_k_cnt    = 4'd4;

endpackage

//--- dp_rx_ctl.sv
// Receive lane control registers
// Wishbone classic slave holding enable and MST mode,
// pulsing the counter clear, and reading back lock and counters

module dp_rx_ctl
(
    input  logic                    CLK_IN,
    input  logic                    RST_IN,
    input  dp_regs_pkg::wb_req_t    wb_req,
    output dp_regs_pkg::wb_rsp_t    wb_rsp,
    input  logic                    lock,
    input  dp_regs_pkg::dp_stats_t  stats,
    output dp_regs_pkg::dp_ctl_t    ctl,
    output logic                    stat_clr
);
    import dp_regs_pkg::*;

    typedef enum logic
    {
        st_idle,
        st_ack
    } wb_state_t;

    wb_state_t  state;
    wb_state_t  state_nxt;
    logic       req;
    logic       wr_ctl;
    wb_dat_t    rd_dat;
    wb_dat_t    rd_dat_r;

    // New access, only taken while ack is low
    assign req = wb_req.cyc && wb_req.stb && (state == st_idle);

    // Only reg_ctl is writable
    assign wr_ctl = req && wb_req.we && (wb_req.adr == reg_ctl);

    // Ack lasts one cycle, then back to idle
    always_comb
    begin
        state_nxt = state;
        case (state)
            st_idle:
            begin
                if (req)
                    state_nxt = st_ack;
            end
            st_ack:
                state_nxt = st_idle;
            default:
                state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            state <= st_idle;
        else
            state <= state_nxt;
    end

    // Read mux, unmapped words read zero
    always_comb
    begin
        case (wb_req.adr)
            reg_ctl:      rd_dat = wb_dat_t'(ctl);
            reg_status:   rd_dat = wb_dat_t'(lock);
            reg_sr_cnt:   rd_dat = wb_dat_t'(stats.sr_cnt);
            reg_loss_cnt: rd_dat = wb_dat_t'(stats.lock_loss_cnt);
            reg_k_cnt:    rd_dat = wb_dat_t'(stats.k_cnt);
            default:      rd_dat = '0;
        endcase
    end

    // Captured with the request, valid during ack
    always_ff @(posedge CLK_IN)
    begin
        if (req)
            rd_dat_r <= rd_dat;
    end

    // Write lands on the edge that raises ack
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            ctl      <= '0;
            stat_clr <= 1'b0;
        end
        else
        begin
            stat_clr <= 1'b0;
            if (wr_ctl)
            begin
                ctl      <= dp_ctl_t'(wb_req.dat[$bits(dp_ctl_t)-1:0]);
                // Self-clearing, never stored
                stat_clr <= wb_req.dat[dp_stat_clr];
            end
        end
    end

    assign wb_rsp.ack = (state == st_ack);
    assign wb_rsp.dat = rd_dat_r;

endmodule

//--- dp_rx_descrambler.sv
// DisplayPort receive descrambler
// Rebuilds the scrambler sequence across all symbols of a clock,
// restarts it on SR symbols, handles SST and MST K symbols
// and drops lock when SR symbols stop arriving

module dp_rx_descrambler
(
    input  logic                    CLK_IN,
    input  logic                    RST_IN,
    input  dp_regs_pkg::dp_ctl_t    ctl,
    input  dp_sym_pkg::dp_link_t    link_in,
    output dp_sym_pkg::dp_link_t    link_out,
    output logic                    sr_det
);
    import dp_sym_pkg::*;
    import dp_regs_pkg::*;

    // Eight shifts of the Galois LFSR, one per data bit
    function automatic dp_lfsr_t lfsr_step8(dp_lfsr_t state);
        dp_lfsr_t s;
        logic     fb;
        s = state;
        for (int b = 0; b < 8; b++)
        begin
            fb = s[15];
            s  = {s[14:0], 1'b0};
            if (fb)
                s = s ^ dp_lfsr_poly;
        end
        return s;
    endfunction

    // Bit-reversed upper byte is the scrambling key
    function automatic logic [7:0] lfsr_key(dp_lfsr_t state);
        logic [7:0] key;
        for (int j = 0; j < 8; j++)
            key[j] = state[15-j];
        return key;
    endfunction

    // Position of a K symbol in the MST code table
    function automatic logic [2:0] k_index(dp_sym_t sym);
        case (sym)
            sym_k23_7: k_index = 3'd0;
            sym_k27_7: k_index = 3'd1;
            sym_k28_0: k_index = 3'd2;
            sym_k28_2: k_index = 3'd3;
            sym_k28_3: k_index = 3'd4;
            sym_k28_6: k_index = 3'd5;
            sym_k29_7: k_index = 3'd6;
            sym_k30_7: k_index = 3'd7;
            default:   k_index = 3'd0;
        endcase
    endfunction

    dp_ctl_t                ctl_r;
    logic                   lock_in_r;
    dp_sym_t                sr_sym;
    logic [dp_spl-1:0]      sr_hit;
    logic [dp_spl-1:0]      lfsr_rst;
    logic                   lfsr_rst0;
    dp_lfsr_t               lfsr_reg;
    dp_lfsr_t [dp_spl-1:0]  lfsr;
    dp_sym_t [dp_spl-1:0]   dnext;
    dp_sym_t [dp_spl-1:0]   dout;
    dp_wdg_cnt_t            wdg_cnt;
    logic                   wdg_end;
    logic                   lock_r;

    // Control and sink lock, one cycle late
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            ctl_r     <= '0;
            lock_in_r <= 1'b0;
        end
        else
        begin
            ctl_r     <= ctl;
            lock_in_r <= link_in.lock;
        end
    end

    // SR is K28.5 in MST, K28.0 in SST
    assign sr_sym = ctl_r.mst ? sym_k28_5 : sym_k28_0;

    always_comb
    begin
        for (int i = 0; i < dp_spl; i++)
            sr_hit[i] = (link_in.sym[i] == sr_sym);
    end

    assign sr_det = |sr_hit;

    // SR in the last slot restarts slot 0 of the next clock
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            lfsr_rst0 <= 1'b0;
        else
            lfsr_rst0 <= sr_hit[dp_spl-1];
    end

    // Other slots restart behind an SR in the slot before
    assign lfsr_rst = {sr_hit[dp_spl-2:0], lfsr_rst0};

    // Chain of steps from the registered state
    always_comb
    begin
        dp_lfsr_t prev;
        prev = lfsr_reg;
        for (int i = 0; i < dp_spl; i++)
        begin
            if (lfsr_rst[i])
                lfsr[i] = dp_lfsr_seed;
            else
                lfsr[i] = lfsr_step8(prev);
            prev = lfsr[i];
        end
    end

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            lfsr_reg <= dp_lfsr_seed;
        else
            lfsr_reg <= lfsr[dp_spl-1];
    end

    // Per-slot output symbol
    always_comb
    begin
        for (int i = 0; i < dp_spl; i++)
        begin
            if (!ctl_r.en)
                dnext[i] = link_in.sym[i];
            else if (link_in.sym[i][8])
            begin
                // MST sends the table index scrambled by bits 13 to 15
                if (ctl_r.mst)
                    dnext[i] = {4'b1000, 2'b00,
                                k_index(link_in.sym[i]) ^ {lfsr[i][13], lfsr[i][14], lfsr[i][15]}};
                else if (sr_hit[i])
                    dnext[i] = sym_bs;
                else
                    dnext[i] = link_in.sym[i];
            end
            else
                dnext[i] = {1'b0, link_in.sym[i][7:0] ^ lfsr_key(lfsr[i])};
        end
    end

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            dout <= '0;
        else
            dout <= dnext;
    end

    // Watchdog, reloaded by SR while the sink is locked
    assign wdg_end = (wdg_cnt == '0);

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            wdg_cnt <= '0;
        else if (lock_in_r && sr_det)
            wdg_cnt <= dp_wdg_load;
        else if (!wdg_end)
            wdg_cnt <= wdg_cnt - dp_wdg_cnt_t'(1);
    end

    // Lock held high while disabled
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            lock_r <= 1'b1;
        else if (ctl_r.en)
            lock_r <= !wdg_end;
        else
            lock_r <= 1'b1;
    end

    assign link_out.lock = lock_r;
    assign link_out.sym  = dout;

endmodule

//--- dp_rx_lane.sv
// DisplayPort receive lane top level
// Register slave, descrambler and symbol statistics
// for one lane group

module dp_rx_lane
(
    input  logic                    CLK_IN,
    input  logic                    RST_IN,
    input  dp_regs_pkg::wb_req_t    wb_req,
    output dp_regs_pkg::wb_rsp_t    wb_rsp,
    input  dp_sym_pkg::dp_link_t    link_in,
    output dp_sym_pkg::dp_link_t    link_out
);
    import dp_regs_pkg::*;

    dp_ctl_t    ctl;
    dp_stats_t  stats;
    logic       stat_clr;
    logic       sr_det;

    // Registers and bus slave
    dp_rx_ctl dp_rx_ctl_i
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .lock       (link_out.lock),
        .stats      (stats),
        .ctl        (ctl),
        .stat_clr   (stat_clr)
    );

    // Link datapath
    dp_rx_descrambler dp_rx_descrambler_i
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .ctl        (ctl),
        .link_in    (link_in),
        .link_out   (link_out),
        .sr_det     (sr_det)
    );

    // Taps the descrambled stream
    dp_rx_sym_stats dp_rx_sym_stats_i
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .link_out   (link_out),
        .sr_det     (sr_det),
        .stat_clr   (stat_clr),
        .stats      (stats)
    );

endmodule

//--- dp_rx_lane_properties.sv
// Bound checks for the receive lane
// Wishbone acknowledge rules and the link output after reset

module dp_rx_lane_properties
(
    input  logic                    CLK_IN,
    input  logic                    RST_IN,
    input  dp_regs_pkg::wb_req_t    wb_req,
    input  dp_regs_pkg::wb_rsp_t    wb_rsp,
    input  dp_sym_pkg::dp_link_t    link_out
);
    timeunit 1ns;
    timeprecision 1ns;

    int unsigned fail_cnt = 0;

    // Ack is a single-cycle pulse
    ack_pulse: assert property (@(posedge CLK_IN) disable iff (RST_IN)
        wb_rsp.ack |=> !wb_rsp.ack)
    else
    begin
        fail_cnt++;
        $error("ack stayed high for two cycles");
    end

    // No ack without a request in the cycle before
    ack_after_req: assert property (@(posedge CLK_IN) disable iff (RST_IN)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
    else
    begin
        fail_cnt++;
        $error("ack without cyc and stb");
    end

    // Symbols still cleared right after reset
    sym_after_rst: assert property (@(posedge CLK_IN)
        $fell(RST_IN) |-> (link_out.sym == '0))
    else
    begin
        fail_cnt++;
        $error("link_out symbols not zero after reset");
    end

endmodule

//--- dp_rx_sym_stats.sv
// Symbol statistics for the receive lane
// Saturating counters of SR events, lock losses and K symbols
// seen on the descrambled stream

module dp_rx_sym_stats
(
    input  logic                    CLK_IN,
    input  logic                    RST_IN,
    input  dp_sym_pkg::dp_link_t    link_out,
    input  logic                    sr_det,
    input  logic                    stat_clr,
    output dp_regs_pkg::dp_stats_t  stats
);
    import dp_sym_pkg::*;
    import dp_regs_pkg::*;

    // Add without wrap, sticks at all ones
    function automatic dp_stat_cnt_t sat_add(dp_stat_cnt_t cnt, dp_stat_cnt_t inc);
        logic [$bits(dp_stat_cnt_t):0] sum;
        sum = {1'b0, cnt} + {1'b0, inc};
        if (sum[$bits(dp_stat_cnt_t)])
            return '1;
        return sum[$bits(dp_stat_cnt_t)-1:0];
    endfunction

    logic           lock_d;
    logic           lock_fall;
    dp_stat_cnt_t   k_inc;

    // K symbols in this clock
    always_comb
    begin
        k_inc = '0;
        for (int i = 0; i < dp_spl; i++)
            k_inc = k_inc + dp_stat_cnt_t'(link_out.sym[i][8]);
    end

    // Lock starts high out of reset
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            lock_d <= 1'b1;
        else
            lock_d <= link_out.lock;
    end

    assign lock_fall = lock_d && !link_out.lock;

    // Clear wins over any increment
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            stats <= '0;
        else if (stat_clr)
            stats <= '0;
        else
        begin
            stats.sr_cnt        <= sat_add(stats.sr_cnt, dp_stat_cnt_t'(sr_det));
            stats.lock_loss_cnt <= sat_add(stats.lock_loss_cnt, dp_stat_cnt_t'(lock_fall));
            stats.k_cnt         <= sat_add(stats.k_cnt, k_inc);
        end
    end

endmodule

//--- dp_sym_pkg.sv
// DisplayPort link symbol definitions
// Symbol and scrambler types, K codes, the per-clock link bundle
// and the lock watchdog length for the receive lane path

package dp_sym_pkg;

    // Symbols carried per clock
    localparam int dp_spl = 2;

    // K flag in bit 8, data byte below
    typedef logic [8:0] dp_sym_t;

    // Scrambler LFSR state
    typedef logic [15:0] dp_lfsr_t;

    // Lock watchdog counter
    typedef logic [11:0] dp_wdg_cnt_t;

    // One clock of link symbols plus lock
    typedef struct packed {
        logic                   lock;
        dp_sym_t [dp_spl-1:0]   sym;
    } dp_link_t;

    // K codes with the K flag set
    localparam dp_sym_t sym_k23_7 = 9'h1f7;
    localparam dp_sym_t sym_k27_7 = 9'h1fb;
    localparam dp_sym_t sym_k28_0 = 9'h11c;
    localparam dp_sym_t sym_k28_2 = 9'h15c;
    localparam dp_sym_t sym_k28_3 = 9'h17c;
    localparam dp_sym_t sym_k28_5 = 9'h1bc;
    localparam dp_sym_t sym_k28_6 = 9'h1dc;
    localparam dp_sym_t sym_k29_7 = 9'h1fd;
    localparam dp_sym_t sym_k30_7 = 9'h1fe;
    // Blanking start shares the K28.5 code
    localparam dp_sym_t sym_bs    = sym_k28_5;

    // Taps of x^16 + x^5 + x^4 + x^3 + 1
    localparam dp_lfsr_t dp_lfsr_poly = 16'h0039;
    localparam dp_lfsr_t dp_lfsr_seed = 16'hffff;

    // Short reload so the watchdog trips in simulation
    localparam dp_wdg_cnt_t dp_wdg_load = 12'd4095;

endpackage

//--- sources.f
dp_sym_pkg.sv
dp_regs_pkg.sv
dp_rx_descrambler.sv
dp_rx_sym_stats.sv
dp_rx_ctl.sv
dp_rx_lane.sv
dp_rx_lane_properties.sv
tb_dp_rx_lane.sv

//--- tb_dp_rx_lane.sv
// Testbench for the DisplayPort receive lane
// Table of link patterns and register checks, with a scrambler
// and watchdog model that predicts link_out cycle by cycle

module tb_dp_rx_lane;
    timeunit 1ns;
    timeprecision 1ns;

    import dp_sym_pkg::*;
    import dp_regs_pkg::*;

    typedef enum logic [1:0] {pat_sr, pat_kmix, pat_quiet} pat_t;
    typedef enum logic [2:0] {chk_none, chk_ctl, chk_cnt, chk_lock, chk_clr} chk_t;

    typedef struct packed {
        dp_ctl_t        ctl;
        pat_t           pat;
        logic [3:0]     slot;
        logic [15:0]    cycles;
        chk_t           chk;
    } row_t;

    localparam int n_rows = 9;

    // Control, pattern, SR slot, cycles, result check
    localparam row_t rows [n_rows] = '{
        '{dp_ctl_t'(2'b00), pat_sr,    4'd0, 16'd12, chk_none},
        '{dp_ctl_t'(2'b01), pat_sr,    4'd0, 16'd24, chk_ctl},
        '{dp_ctl_t'(2'b01), pat_sr,    4'd1, 16'd24, chk_cnt},
        '{dp_ctl_t'(2'b11), pat_kmix,  4'd0, 16'd24, chk_none},
        '{dp_ctl_t'(2'b11), pat_kmix,  4'd1, 16'd24, chk_cnt},
        '{dp_ctl_t'(2'b01), pat_quiet, 4'd0, 16'(dp_wdg_load) + 16'd16, chk_lock},
        '{dp_ctl_t'(2'b01), pat_sr,    4'd1, 16'd12, chk_lock},
        '{dp_ctl_t'(2'b01), pat_sr,    4'd0, 16'd8,  chk_clr},
        '{dp_ctl_t'(2'b00), pat_kmix,  4'd0, 16'd16, chk_cnt}
    };

    // MST K-code table in index order
    localparam dp_sym_t k_table [8] = '{sym_k23_7, sym_k27_7, sym_k28_0, sym_k28_2,
                                        sym_k28_3, sym_k28_6, sym_k29_7, sym_k30_7};

    logic           CLK_IN;
    logic           RST_IN = 1'b1;
    wb_req_t        wb_req = '0;
    wb_rsp_t        wb_rsp;
    dp_link_t       link_in = '{lock: 1'b1, sym: '0};
    dp_link_t       link_out;

    dp_link_t       sym_q [$];
    int             q_rd = 0;
    logic [31:0]    rnd = 32'h7cecb087;
    dp_ctl_t        ctl_exp = '0;
    logic           chk_on = 1'b0;
    int             n_chk = 0;
    int             n_err = 0;
    int             link_chk = 0;
    int             link_err = 0;

    // Model state, one cycle behind the stimulus
    dp_ctl_t        m_ctl_r;
    dp_lfsr_t       m_lfsr;
    logic           m_rst0;
    logic           m_lock_in_r;
    dp_wdg_cnt_t    m_wdg;
    dp_link_t       m_exp;
    dp_stats_t      m_stats;
    dp_stats_t      m_base = '0;

    dp_rx_lane dp_rx_lane_i
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .link_in    (link_in),
        .link_out   (link_out)
    );

    bind dp_rx_lane dp_rx_lane_properties props_i
    (
        .CLK_IN     (CLK_IN),
        .RST_IN     (RST_IN),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .link_out   (link_out)
    );

    initial
    begin
        CLK_IN = 1'b0;
        forever
            #50 CLK_IN = ~CLK_IN;
    end

    // Galois LFSR, one shift per bit taken
    function automatic logic [7:0] rand_bits(int n);
        logic [7:0] v;
        v = '0;
        for (int b = 0; b < n; b++)
        begin
            v   = {v[6:0], rnd[0]};
            rnd = rnd[0] ? ((rnd >> 1) ^ 32'h80200003) : (rnd >> 1);
        end
        return v;
    endfunction

    // Scrambler advance over one symbol, eight shifts
    function automatic dp_lfsr_t scr_next(dp_lfsr_t st);
        dp_lfsr_t s;
        s = st;
        repeat (8)
            s = s[15] ? ((s << 1) ^ dp_lfsr_poly) : (s << 1);
        return s;
    endfunction

    function automatic dp_sym_t expect_sym(dp_sym_t s, dp_lfsr_t st, dp_ctl_t c, logic is_sr);
        logic [7:0] key;
        logic [2:0] idx;
        // Key is the upper state byte, bit reversed
        for (int j = 0; j < 8; j++)
            key[7-j] = st[8+j];
        idx = 3'd0;
        for (int k = 0; k < 8; k++)
            if (k_table[k] == s)
                idx = 3'(k);
        if (!c.en)
            return s;
        if (!s[8])
            return {1'b0, s[7:0] ^ key};
        if (c.mst)
            return {6'b100000, idx ^ {st[13], st[14], st[15]}};
        return is_sr ? sym_bs : s;
    endfunction

    // Reference model of descrambler, watchdog and counters
    always @(posedge CLK_IN or posedge RST_IN)
    begin : model
        dp_lfsr_t   st;
        logic       restart;
        logic       hit;
        logic       srdet;
        dp_sym_t    sr_code;
        dp_link_t   nxt;
        if (RST_IN)
        begin
            m_ctl_r     = '0;
            m_lfsr      = dp_lfsr_seed;
            m_rst0      = 1'b0;
            m_lock_in_r = 1'b0;
            m_wdg       = '0;
            m_exp.lock  = 1'b1;
            m_exp.sym   = '0;
            m_stats     = '0;
        end
        else
        begin
            sr_code  = m_ctl_r.mst ? sym_k28_5 : sym_k28_0;
            st       = m_lfsr;
            restart  = m_rst0;
            srdet    = 1'b0;
            nxt.lock = m_ctl_r.en ? (m_wdg != '0) : 1'b1;
            for (int i = 0; i < dp_spl; i++)
            begin
                st         = restart ? dp_lfsr_seed : scr_next(st);
                hit        = (link_in.sym[i] == sr_code);
                nxt.sym[i] = expect_sym(link_in.sym[i], st, m_ctl_r, hit);
                restart    = hit;
                srdet      = srdet | hit;
            end
            m_lfsr = st;
            m_rst0 = restart;
            // Reload only while the sink reported lock
            if (m_lock_in_r && srdet)
                m_wdg = dp_wdg_load;
            else if (m_wdg != '0)
                m_wdg = m_wdg - 12'd1;
            m_lock_in_r = link_in.lock;
            m_ctl_r     = ctl_exp;
            if (m_exp.lock && !nxt.lock)
                m_stats.lock_loss_cnt = m_stats.lock_loss_cnt + 16'd1;
            m_stats.sr_cnt = m_stats.sr_cnt + dp_stat_cnt_t'(srdet);
            for (int i = 0; i < dp_spl; i++)
                m_stats.k_cnt = m_stats.k_cnt + dp_stat_cnt_t'(nxt.sym[i][8]);
            m_exp = nxt;
        end
    end

    // Stimulus from the queue, idle symbols when it runs dry
    always @(negedge CLK_IN)
    begin
        if (q_rd < sym_q.size())
        begin
            link_in = sym_q[q_rd];
            q_rd++;
        end
        else
        begin
            link_in.lock = 1'b1;
            link_in.sym  = '0;
        end
    end

    task automatic check_link(dp_link_t got, dp_link_t exp);
        link_chk++;
        if (got !== exp)
        begin
            link_err++;
            $display("Error at %0t ns: link_out lock %b sym %h, expected lock %b sym %h",
                     $time, got.lock, got.sym, exp.lock, exp.sym);
        end
    endtask

    // Every cycle once out of reset
    always @(negedge CLK_IN)
    begin
        if (chk_on)
            check_link(link_out, m_exp);
    end

    task automatic check_reg(wb_dat_t got, wb_dat_t exp, string what);
        n_chk++;
        if (got !== exp)
        begin
            n_err++;
            $display("Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_cnt(dp_stat_cnt_t got, dp_stat_cnt_t exp, string what);
        n_chk++;
        if (got !== exp)
        begin
            n_err++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // One classic cycle, started and ended on a falling edge
    task automatic wb_access(logic we, wb_adr_t adr, wb_dat_t wdat, output wb_dat_t rdat);
        int wait_cnt;
        rdat     = '0;
        wait_cnt = 0;
        wb_req   = '{1'b1, 1'b1, we, adr, wdat};
        @(negedge CLK_IN);
        while (!wb_rsp.ack && wait_cnt < 16)
        begin
            wait_cnt++;
            @(negedge CLK_IN);
        end
        wb_req = '0;
        if (!wb_rsp.ack)
        begin
            n_err++;
            $display("Bus access to address %0h got no acknowledge", adr);
            return;
        end
        rdat = wb_rsp.dat;
        if (we && adr == reg_ctl)
        begin
            ctl_exp = dp_ctl_t'(wdat[$bits(dp_ctl_t)-1:0]);
            if (wdat[dp_stat_clr])
                m_base = m_stats;
        end
        @(negedge CLK_IN);
        if (wb_rsp.ack)
        begin
            n_err++;
            $display("Acknowledge at address %0h lasted more than one cycle", adr);
        end
    endtask

    task automatic read_reg(wb_adr_t adr, wb_dat_t exp, string what);
        wb_dat_t rd;
        wb_access(1'b0, adr, '0, rd);
        check_reg(rd, exp, what);
    endtask

    task automatic read_cnt(wb_adr_t adr, dp_stat_cnt_t exp, string what);
        wb_dat_t rd;
        wb_access(1'b0, adr, '0, rd);
        check_cnt(dp_stat_cnt_t'(rd), exp, what);
    endtask

    // Queue one row of symbols and wait until it has left
    task automatic send_row(row_t r);
        dp_link_t   lk;
        logic [2:0] kidx;
        for (int c = 0; c < int'(r.cycles); c++)
        begin
            lk.lock = 1'b1;
            for (int i = 0; i < dp_spl; i++)
            begin
                if (r.pat == pat_quiet)
                    lk.sym[i] = '0;
                else if (c == 0 && i == int'(r.slot))
                    lk.sym[i] = r.ctl.mst ? sym_k28_5 : sym_k28_0;
                else if (r.pat == pat_kmix && rand_bits(1) == 8'd1)
                begin
                    kidx      = 3'(rand_bits(3));
                    lk.sym[i] = k_table[kidx];
                end
                else
                    lk.sym[i] = {1'b0, rand_bits(8)};
            end
            sym_q.push_back(lk);
        end
        while (q_rd < sym_q.size())
            @(negedge CLK_IN);
        repeat (4) @(negedge CLK_IN);
    endtask

    function automatic dp_stat_cnt_t since_clr(dp_stat_cnt_t now, dp_stat_cnt_t base);
        return now - base;
    endfunction

    initial
    begin
        wb_dat_t    rd;
        row_t       r;
        pat_t       pat;
        chk_t       chk;
        int         err0;
        int         n_fail;
        n_fail = 0;
        repeat (16) @(negedge CLK_IN);
        RST_IN = 1'b0;
        chk_on = 1'b1;
        for (int t = 0; t < n_rows; t++)
        begin
            r    = rows[t];
            err0 = n_err + link_err;
            if (r.ctl != ctl_exp)
            begin
                wb_access(1'b1, reg_ctl, wb_dat_t'(r.ctl), rd);
                repeat (3) @(negedge CLK_IN);
            end
            send_row(r);
            case (r.chk)
                chk_ctl:
                begin
                    read_reg(reg_ctl, wb_dat_t'(ctl_exp), "reg_ctl");
                    wb_access(1'b1, 4'hc, '1, rd);
                    read_reg(4'hc, '0, "unmapped word 0xc");
                    read_reg(4'h7, '0, "unmapped word 0x7");
                    read_reg(reg_ctl, wb_dat_t'(ctl_exp), "reg_ctl after unmapped write");
                end
                chk_cnt:
                begin
                    read_cnt(reg_sr_cnt, since_clr(m_stats.sr_cnt, m_base.sr_cnt), "sr_cnt");
                    read_cnt(reg_k_cnt, since_clr(m_stats.k_cnt, m_base.k_cnt), "k_cnt");
                end
                chk_lock:
                begin
                    read_reg(reg_status, wb_dat_t'(m_exp.lock), "reg_status");
                    read_cnt(reg_loss_cnt,
                             since_clr(m_stats.lock_loss_cnt, m_base.lock_loss_cnt), "loss_cnt");
                end
                chk_clr:
                begin
                    // Bit 2 clears, control bits stay as they are
                    wb_access(1'b1, reg_ctl, wb_dat_t'(ctl_exp) | 32'h4, rd);
                    repeat (2) @(negedge CLK_IN);
                    read_cnt(reg_sr_cnt, 16'd0, "sr_cnt after clear");
                    read_cnt(reg_loss_cnt, 16'd0, "loss_cnt after clear");
                    read_cnt(reg_k_cnt, 16'd0, "k_cnt after clear");
                end
                default:
                    ;
            endcase
            pat = r.pat;
            chk = r.chk;
            if (n_err + link_err == err0)
                $display("test %0d %s %s: ok", t, pat.name(), chk.name());
            else
            begin
                n_fail++;
                $display("test %0d %s %s: FAILED with %0d errors", t, pat.name(), chk.name(),
                         n_err + link_err - err0);
            end
        end
        n_err = n_err + int'(dp_rx_lane_i.props_i.fail_cnt);
        $display("%0d tests, %0d failed, %0d checks, %0d errors", n_rows, n_fail,
                 n_chk + link_chk, n_err + link_err);
        if (n_err + link_err == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // Run limit from the table, 64 cycles per row for bus access and gaps
    initial
    begin
        longint longest;
        longest = 0;
        for (int t = 0; t < n_rows; t++)
            if (longint'(rows[t].cycles) > longest)
                longest = longint'(rows[t].cycles);
        #((longint'(n_rows) * (longest + 64) + 32) * 100);
        $display("Watchdog timer expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

endmodule
